//--- vlog.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/decode_1st.sv
hdl/decode_2nd.sv
hdl/schedule_1st.sv
hdl/register_file.sv
hdl/execute.sv
hdl/int_pipe_top.sv
verif/int_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module int_pipe_tb \
    -o int_pipe_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/int_pipe_sim > sim.log 2>&1

grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/int_pipe_tb.sv
`default_nettype none

`include "rv_core_params.svh"

module int_pipe_tb;
    import rv_core_pkg::*;

    localparam int NUM_INSTR   = 3000;
    localparam int CYCLE_LIMIT = NUM_INSTR * 2 + 200;

    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    // One pipeline slot of the occupancy shadow
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         ins;
    } slot_t;

    logic    CLK;
    logic    rst;
    logic    flush;
    logic    stall;
    fetch_t  fetch;
    retire_t retire;

    integer              seed;
    slot_t               sh [0:4];
    logic [`RV_XLEN-1:0] mregs [0:31];
    logic [`RV_XLEN-1:0] next_pc;
    int                  retired;
    int                  cycles;

    int_pipe_top dut0 (
        .CLK    (CLK),
        .rst    (rst),
        .flush  (flush),
        .stall  (stall),
        .fetch  (fetch),
        .retire (retire)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ====================
    // ISA model
    // ====================

    function automatic logic is_supported(input logic [31:0] ins);
        return (ins[6:0] == OPC_REG) || (ins[6:0] == OPC_IMM) ||
               (ins[6:0] == OPC_LUI) || (ins[6:0] == OPC_AUIPC);
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] ins, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] uimm;
        logic [31:0] res;
        a    = mregs[ins[19:15]];
        b    = (ins[6:0] == OPC_REG) ? mregs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        uimm = {ins[31:12], 12'b0};
        res  = '0;
        if (ins[6:0] == OPC_LUI) begin
            res = uimm;
        end else if (ins[6:0] == OPC_AUIPC) begin
            res = pc + uimm;
        end else if ((ins[6:0] == OPC_REG) || (ins[6:0] == OPC_IMM)) begin
            case (ins[14:12])
                3'd0: res = ((ins[6:0] == OPC_REG) && ins[30]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: res = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: res = a | b;
                3'd7: res = a & b;
            endcase
        end
        return res;
    endfunction

    // ====================
    // Stimulus
    // ====================

    // Registers limited to x0..x7 so dependencies are dense
    task automatic make_instr(output logic [31:0] ins);
        logic [31:0] r;
        logic [31:0] r2;
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [6:0]  opc;
        r   = $random(seed);
        r2  = $random(seed);
        sel = {$random(seed)} % 100;
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        if (sel < 5) begin
            case (r[13:12])
                2'd0:    opc = 7'b0000011;
                2'd1:    opc = 7'b0100011;
                2'd2:    opc = 7'b1100011;
                default: opc = 7'b1101111;
            endcase
            ins = {r2[31:12], rd, opc};
        end else if (sel < 35) begin
            f7  = (((f3 == 3'd0) || (f3 == 3'd5)) && r[14]) ? 7'h20 : 7'h00;
            ins = {f7, rs2, rs1, f3, rd, OPC_REG};
        end else if (sel < 75) begin
            imm12 = r2[11:0];
            if (f3 == 3'd1) begin
                imm12[11:5] = 7'h00;
            end else if (f3 == 3'd5) begin
                imm12[11:5] = r[14] ? 7'h20 : 7'h00;
            end
            ins = {imm12, rs1, f3, rd, OPC_IMM};
        end else if (sel < 88) begin
            ins = {r2[19:0], rd, OPC_LUI};
        end else begin
            ins = {r2[19:0], rd, OPC_AUIPC};
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] ins;
        make_instr(ins);
        stall       = ({$random(seed)} % 8) == 0;
        flush       = ({$random(seed)} % 20) == 0;
        fetch.valid = ({$random(seed)} % 100) < 85;
        fetch.pc    = next_pc;
        fetch.instr = ins;
        if (fetch.valid && !stall && !flush) begin
            next_pc = next_pc + 4;
        end
    endtask

    // ====================
    // Checks and shadow
    // ====================

    task automatic check_retire();
        logic        exp_valid;
        logic        exp_we;
        logic [31:0] exp_data;
        logic [31:0] ins;
        ins       = sh[4].ins;
        exp_valid = sh[4].valid && !stall;
        compare("retire_valid", 32'(exp_valid), 32'(retire.valid));
        if (exp_valid) begin
            exp_we   = is_supported(ins) && (ins[11:7] != 5'd0);
            exp_data = model_result(ins, sh[4].pc);
            compare("retire_pc", sh[4].pc, retire.pc);
            compare("retire_rd", 32'(ins[11:7]), 32'(retire.rd));
            compare("retire_rd_we", 32'(exp_we), 32'(retire.rd_we));
            if (exp_we) begin
                compare("retire_data", exp_data, retire.data);
                mregs[ins[11:7]] = exp_data;
            end else if (!is_supported(ins)) begin
                compare("retire_data_unsupported", 32'd0, retire.data);
            end
            retired++;
        end
    endtask

    // Mirrors the coming edge: back end follows stall, front three follow flush first
    task automatic advance_shadow();
        if (!stall) begin
            sh[4] = sh[3];
            sh[3] = sh[2];
        end
        if (flush) begin
            sh[0].valid = 1'b0;
            sh[1].valid = 1'b0;
            sh[2].valid = 1'b0;
        end else if (!stall) begin
            sh[2] = sh[1];
            sh[1] = sh[0];
            sh[0] = '{valid: fetch.valid, pc: fetch.pc, ins: fetch.instr};
        end
    endtask

    initial begin
        seed    = 32'h15f5;
        rst     = 1'b1;
        flush   = 1'b0;
        stall   = 1'b0;
        fetch   = '0;
        next_pc = '0;
        retired = 0;
        cycles  = 0;
        for (int i = 0; i < 5; i++) begin
            sh[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;

        while (retired < NUM_INSTR) begin
            drive_inputs();
            #2;
            check_retire();
            advance_shadow();
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("ERRORS FOUND");
                $fatal(1, "timeout after %0d cycles with %0d of %0d instructions retired",
                       cycles, retired, NUM_INSTR);
            end
            @(negedge CLK);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/int_pipe_top.sv
`default_nettype none

`include "rv_core_params.svh"

module int_pipe_top (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 stall,
    input  rv_core_pkg::fetch_t  fetch,
    output rv_core_pkg::retire_t retire
);
    import rv_core_pkg::*;

    dec1_t               dec1;
    uop_t                uop_dec;
    uop_t                uop_sch;
    retire_t             ex_retire;
    logic                wr_en;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;

    // ====================
    // Front stages
    // ====================

    decode_1st u_decode_1st (
        .CLK   (CLK),
        .rst   (rst),
        .flush (flush),
        .stall (stall),
        .fetch (fetch),
        .dec1  (dec1)
    );

    register_file u_register_file (
        .CLK     (CLK),
        .rst     (rst),
        .rs1     (dec1.rs1),
        .rs2     (dec1.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr      (ex_retire),
        .wr_en   (wr_en)
    );

    decode_2nd u_decode_2nd (
        .CLK     (CLK),
        .rst     (rst),
        .flush   (flush),
        .stall   (stall),
        .dec1    (dec1),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .uop     (uop_dec)
    );

    schedule_1st u_schedule_1st (
        .CLK     (CLK),
        .rst     (rst),
        .flush   (flush),
        .stall   (stall),
        .uop_in  (uop_dec),
        .uop_out (uop_sch)
    );

    // ====================
    // Back end
    // ====================

    execute u_execute (
        .CLK    (CLK),
        .rst    (rst),
        .stall  (stall),
        .uop    (uop_sch),
        .retire (ex_retire),
        .wr_en  (wr_en)
    );

    // Retire is only visible on the edge the write commits
    assign retire = '{
        valid: ex_retire.valid & wr_en,
        pc:    ex_retire.pc,
        rd:    ex_retire.rd,
        rd_we: ex_retire.rd_we,
        data:  ex_retire.data
    };

endmodule

`default_nettype wire

//--- hdl/execute.sv
`default_nettype none

`include "rv_core_params.svh"

module execute (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 stall,
    input  rv_core_pkg::uop_t    uop,
    output rv_core_pkg::retire_t retire,
    output logic                 wr_en
);
    import rv_core_pkg::*;

    retire_t             exe_q;
    retire_t             wb_q;
    // Last committed write, bridges the gap between writeback and the decode_2nd capture
    retire_t             hist_q;
    retire_t             exe_d;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_fwd;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;

    function automatic logic hit(input retire_t r, input logic [`RV_REG_AW-1:0] src);
        return r.valid && r.rd_we && (r.rd == src);
    endfunction

    // ====================
    // Operand forwarding
    // ====================

    // Newest producer first
    function automatic logic [`RV_XLEN-1:0] forward(
        input logic [`RV_REG_AW-1:0] src,
        input logic [`RV_XLEN-1:0]   cap,
        input retire_t               e,
        input retire_t               w,
        input retire_t               h
    );
        if (src == '0) begin
            return cap;
        end else if (hit(e, src)) begin
            return e.data;
        end else if (hit(w, src)) begin
            return w.data;
        end else if (hit(h, src)) begin
            return h.data;
        end
        return cap;
    endfunction

    always_comb begin
        op_a    = forward(uop.rs1, uop.rs1_val, exe_q, wb_q, hist_q);
        rs2_fwd = forward(uop.rs2, uop.rs2_val, exe_q, wb_q, hist_q);
        op_b    = (uop.kind == OPK_ALU_IMM) ? uop.imm : rs2_fwd;
    end

    // ====================
    // ALU
    // ====================

    always_comb begin
        case (uop.funct3)
            3'b000:  alu_res = uop.alt ? (op_a - op_b) : (op_a + op_b);
            3'b001:  alu_res = op_a << op_b[4:0];
            3'b010:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            3'b011:  alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            3'b100:  alu_res = op_a ^ op_b;
            3'b101:  alu_res = uop.alt ? $unsigned($signed(op_a) >>> op_b[4:0])
                                       : (op_a >> op_b[4:0]);
            3'b110:  alu_res = op_a | op_b;
            default: alu_res = op_a & op_b;
        endcase
    end

    always_comb begin
        exe_d.valid = uop.valid;
        exe_d.pc    = uop.pc;
        exe_d.rd    = uop.rd;
        exe_d.rd_we = uop.rd_we;
        case (uop.kind)
            OPK_ALU_REG, OPK_ALU_IMM: exe_d.data = alu_res;
            OPK_LUI:                  exe_d.data = uop.imm;
            OPK_AUIPC:                exe_d.data = uop.pc + uop.imm;
            default:                  exe_d.data = '0;
        endcase
    end

    // ====================
    // Result registers
    // ====================

    always_ff @(posedge CLK) begin
        if (rst) begin
            exe_q.valid  <= 1'b0;
            wb_q.valid   <= 1'b0;
            hist_q.valid <= 1'b0;
        end else if (!stall) begin
            exe_q  <= exe_d;
            wb_q   <= exe_q;
            hist_q <= wb_q;
        end
    end

    assign retire = wb_q;
    assign wr_en  = wb_q.valid && !stall;

    a_operands_known : assert property (
        @(posedge CLK) disable iff (rst)
        uop.valid |-> !$isunknown({op_a, op_b})
    );

    // rd_we is cleared for x0 back in decode_1st
    a_no_x0_write : assert property (
        @(posedge CLK) disable iff (rst)
        (wr_en && retire.rd_we) |-> (retire.rd != '0)
    );

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none

`include "rv_core_params.svh"

module register_file (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_XLEN-1:0]   rs1_val,
    output logic [`RV_XLEN-1:0]   rs2_val,
    input  rv_core_pkg::retire_t  wr,
    input  logic                  wr_en
);

    logic [`RV_XLEN-1:0] regs [0:(1<<`RV_REG_AW)-1];
    logic                we;

    assign we = wr_en && wr.valid && wr.rd_we;

    // x0 first, then same-edge write-through
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && (wr.rd == addr)) begin
            return wr.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < (1 << `RV_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Entry 0 stays clear only while rd_we is never set for x0 upstream
    a_x0_zero : assert property (
        @(posedge CLK) disable iff (rst)
        regs[0] == '0
    );

endmodule

`default_nettype wire

//--- hdl/schedule_1st.sv
`default_nettype none

module schedule_1st (
    input  logic              CLK,
    input  logic              rst,
    input  logic              flush,
    input  logic              stall,
    input  rv_core_pkg::uop_t uop_in,
    output rv_core_pkg::uop_t uop_out
);

    // Flush wins over stall, payload only moves when the stage advances
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            uop_out.valid <= 1'b0;
        end else if (!stall) begin
            uop_out <= uop_in;
        end
    end

    // Neither the flushed slot nor the one behind it reaches execute
    a_flush_clears : assert property (
        @(posedge CLK) disable iff (rst)
        (flush || $past(flush)) |=> !uop_out.valid
    );

endmodule

`default_nettype wire

//--- hdl/decode_2nd.sv
`default_nettype none

`include "rv_core_params.svh"

module decode_2nd (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,
    input  rv_core_pkg::dec1_t  dec1,
    input  logic [`RV_XLEN-1:0] rs1_val,
    input  logic [`RV_XLEN-1:0] rs2_val,
    output rv_core_pkg::uop_t   uop
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] imm;
    logic                shift_op;
    logic                alt;
    uop_t                uop_d;

    // ====================
    // Immediate generation
    // ====================

    always_comb begin
        case (dec1.kind)
            OPK_ALU_IMM: begin
                imm = {{(`RV_XLEN-12){dec1.instr.i.imm[11]}}, dec1.instr.i.imm};
            end
            OPK_LUI, OPK_AUIPC: begin
                imm = {dec1.instr.u.imm, 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // Bit 30 selects sub only for register ops, sra for both forms
    assign shift_op = (dec1.instr.r.funct3 == 3'b101);
    assign alt = dec1.instr.r.funct7[5] && ((dec1.kind == OPK_ALU_REG) || shift_op);

    always_comb begin
        uop_d.valid   = dec1.valid;
        uop_d.pc      = dec1.pc;
        uop_d.kind    = dec1.kind;
        uop_d.rd      = dec1.rd;
        uop_d.rd_we   = dec1.rd_we;
        uop_d.funct3  = dec1.instr.r.funct3;
        uop_d.alt     = alt;
        uop_d.rs1     = dec1.rs1;
        uop_d.rs2     = dec1.rs2;
        uop_d.rs1_val = rs1_val;
        uop_d.rs2_val = rs2_val;
        uop_d.imm     = imm;
    end

    // ====================
    // Stage register
    // ====================

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            uop.valid <= 1'b0;
        end else if (!stall) begin
            uop <= uop_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_1st.sv
`default_nettype none

module decode_1st (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,
    input  rv_core_pkg::fetch_t fetch,
    output rv_core_pkg::dec1_t  dec1
);
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    instr_u   word;
    op_kind_e kind;
    dec1_t    dec1_d;

    assign word = fetch.instr;

    // Opcode classification
    always_comb begin
        case (word.u.opcode)
            OPC_OP:     kind = OPK_ALU_REG;
            OPC_OP_IMM: kind = OPK_ALU_IMM;
            OPC_LUI:    kind = OPK_LUI;
            OPC_AUIPC:  kind = OPK_AUIPC;
            default:    kind = OPK_NONE;
        endcase
    end

    always_comb begin
        dec1_d.valid = fetch.valid;
        dec1_d.pc    = fetch.pc;
        dec1_d.instr = word;
        dec1_d.kind  = kind;
        dec1_d.rd    = word.u.rd;
        dec1_d.rd_we = (kind != OPK_NONE) && (word.u.rd != '0);
        dec1_d.rs1   = word.r.rs1;
        dec1_d.rs2   = word.r.rs2;
    end

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            dec1.valid <= 1'b0;
        end else if (!stall) begin
            dec1 <= dec1_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_params.svh"

package rv_core_pkg;

    // ====================
    // Instruction formats
    // ====================

    typedef enum logic [2:0] {
        OPK_NONE,
        OPK_ALU_REG,
        OPK_ALU_IMM,
        OPK_LUI,
        OPK_AUIPC
    } op_kind_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    // Same 32-bit word seen through each format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instr_u;

    // ====================
    // Stage payloads
    // ====================

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instr;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        instr_u                instr;
        op_kind_e              kind;
        logic [`RV_REG_AW-1:0] rd;
        logic                  rd_we;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
    } dec1_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        op_kind_e              kind;
        logic [`RV_REG_AW-1:0] rd;
        logic                  rd_we;
        logic [2:0]            funct3;
        logic                  alt;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   rs1_val;
        logic [`RV_XLEN-1:0]   rs2_val;
        logic [`RV_XLEN-1:0]   imm;
    } uop_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  rd_we;
        logic [`RV_XLEN-1:0]   data;
    } retire_t;

endpackage

`default_nettype wire

//--- include/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// ====================
// Core widths
// ====================

// Data and pc width
`define RV_XLEN   32

// Register address width, 32 architectural registers
`define RV_REG_AW 5

`endif
